/* backend_pkg.sv */
package backend_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;

    localparam int unsigned REG_NUM = 32;

    // operation handed from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_CSRRD,
        ALU_CSRWR,
        ALU_NOP
    } alu_op_t;

    // three-register forms, inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // si12 form, inst[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;

    // si20 form, inst[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // csrrd / csrwr share this, rj picks which one
    localparam logic [7:0] OP_CSR = 8'h04;

    // scratch csr numbers
    localparam csr_addr_t CSR_SAVE0 = 14'h0030;
    localparam csr_addr_t CSR_SAVE1 = 14'h0031;
    localparam csr_addr_t CSR_SAVE2 = 14'h0032;
    localparam csr_addr_t CSR_SAVE3 = 14'h0033;

endpackage

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  backend_pkg::reg_addr_t raddr1_i,
    input  backend_pkg::reg_addr_t raddr2_i,
    output backend_pkg::bus32_t    rdata1_o,
    output backend_pkg::bus32_t    rdata2_o,
    input  logic                   we_i,
    input  backend_pkg::reg_addr_t waddr_i,
    input  backend_pkg::bus32_t    wdata_i
);
    import backend_pkg::*;

    // r0 has no storage
    bus32_t regs [1:REG_NUM-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // reads see the old value during a write
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* csr.sv */
`timescale 1ns/1ps

module csr (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  backend_pkg::csr_addr_t raddr_i,
    output backend_pkg::bus32_t    rdata_o,
    input  logic                   we_i,
    input  backend_pkg::csr_addr_t waddr_i,
    input  backend_pkg::bus32_t    wdata_i
);
    import backend_pkg::*;

    bus32_t save0;
    bus32_t save1;
    bus32_t save2;
    bus32_t save3;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
        end else if (we_i) begin
            case (waddr_i)
                CSR_SAVE0: save0 <= wdata_i;
                CSR_SAVE1: save1 <= wdata_i;
                CSR_SAVE2: save2 <= wdata_i;
                CSR_SAVE3: save3 <= wdata_i;
                default: ;
            endcase
        end
    end

    // unimplemented numbers read as zero
    always_comb begin
        case (raddr_i)
            CSR_SAVE0: rdata_o = save0;
            CSR_SAVE1: rdata_o = save1;
            CSR_SAVE2: rdata_o = save2;
            CSR_SAVE3: rdata_o = save3;
            default:   rdata_o = '0;
        endcase
    end

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   inst_req_i,
    input  backend_pkg::bus32_t    inst_pc_i,
    input  backend_pkg::bus32_t    inst_i,
    output logic                   inst_ack_o,
    output backend_pkg::reg_addr_t raddr1_o,
    output backend_pkg::reg_addr_t raddr2_o,
    input  backend_pkg::bus32_t    rdata1_i,
    input  backend_pkg::bus32_t    rdata2_i,
    input  logic                   fwd_valid_i,
    input  logic                   fwd_we_i,
    input  backend_pkg::reg_addr_t fwd_rd_i,
    input  backend_pkg::bus32_t    fwd_data_i,
    output logic                   id_valid_o,
    output backend_pkg::bus32_t    id_pc_o,
    output backend_pkg::alu_op_t   id_op_o,
    output backend_pkg::reg_addr_t id_rd_o,
    output backend_pkg::bus32_t    id_src1_o,
    output backend_pkg::bus32_t    id_src2_o,
    output backend_pkg::csr_addr_t id_csr_o,
    output logic                   id_we_o
);
    import backend_pkg::*;

    logic      capture;
    logic      cap_valid;
    bus32_t    cap_pc;
    bus32_t    cap_inst;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    logic      is_csr;
    logic      fwd1;
    logic      fwd2;
    bus32_t    val1;
    bus32_t    val2;
    alu_op_t   dec_op;
    bus32_t    dec_src2;
    logic      dec_we;

    // four-phase intake, ack follows req down one edge later
    assign capture = inst_req_i && !inst_ack_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_ack_o <= 1'b0;
            cap_valid  <= 1'b0;
        end else begin
            cap_valid <= capture;
            if (capture) begin
                inst_ack_o <= 1'b1;
            end else if (!inst_req_i) begin
                inst_ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            cap_pc   <= inst_pc_i;
            cap_inst <= inst_i;
        end
    end

    assign rd     = cap_inst[4:0];
    assign rj     = cap_inst[9:5];
    assign rk     = cap_inst[14:10];
    assign is_csr = (cap_inst[31:24] == OP_CSR);

    // csrwr takes its new value from rd
    assign raddr1_o = is_csr ? rd : rj;
    assign raddr2_o = rk;

    // previous instruction may still sit in the commit register
    assign fwd1 = fwd_valid_i && fwd_we_i && (fwd_rd_i == raddr1_o) && (raddr1_o != '0);
    assign fwd2 = fwd_valid_i && fwd_we_i && (fwd_rd_i == raddr2_o) && (raddr2_o != '0);
    assign val1 = fwd1 ? fwd_data_i : rdata1_i;
    assign val2 = fwd2 ? fwd_data_i : rdata2_i;

    always_comb begin
        dec_op   = ALU_NOP;
        dec_src2 = val2;
        if (cap_inst[31:22] == OP_ADDI_W) begin
            dec_op   = ALU_ADD;
            dec_src2 = {{20{cap_inst[21]}}, cap_inst[21:10]};
        end else if (cap_inst[31:25] == OP_LU12I_W) begin
            dec_op   = ALU_LUI;
            dec_src2 = {cap_inst[24:5], 12'b0};
        end else if (is_csr) begin
            if (rj == 5'd0) begin
                dec_op = ALU_CSRRD;
            end else if (rj == 5'd1) begin
                dec_op = ALU_CSRWR;
            end
        end else begin
            case (cap_inst[31:15])
                OP_ADD_W: dec_op = ALU_ADD;
                OP_SUB_W: dec_op = ALU_SUB;
                OP_AND:   dec_op = ALU_AND;
                OP_OR:    dec_op = ALU_OR;
                OP_XOR:   dec_op = ALU_XOR;
                OP_SLT:   dec_op = ALU_SLT;
                OP_SLTU:  dec_op = ALU_SLTU;
                default:  dec_op = ALU_NOP;
            endcase
        end
    end

    // r0 and unknown opcodes never write back
    assign dec_we = (dec_op != ALU_NOP) && (rd != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_o <= 1'b0;
            id_we_o    <= 1'b0;
        end else begin
            id_valid_o <= cap_valid;
            id_we_o    <= cap_valid && dec_we;
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o   <= cap_pc;
        id_op_o   <= dec_op;
        id_rd_o   <= rd;
        id_src1_o <= val1;
        id_src2_o <= dec_src2;
        id_csr_o  <= cap_inst[23:10];
    end

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   id_valid_i,
    input  backend_pkg::bus32_t    id_pc_i,
    input  backend_pkg::alu_op_t   id_op_i,
    input  backend_pkg::reg_addr_t id_rd_i,
    input  backend_pkg::bus32_t    id_src1_i,
    input  backend_pkg::bus32_t    id_src2_i,
    input  backend_pkg::csr_addr_t id_csr_i,
    input  logic                   id_we_i,
    output backend_pkg::csr_addr_t csr_raddr_o,
    input  backend_pkg::bus32_t    csr_rdata_i,
    output logic                   commit_valid_o,
    output backend_pkg::bus32_t    commit_pc_o,
    output logic                   commit_we_o,
    output backend_pkg::reg_addr_t commit_rd_o,
    output backend_pkg::bus32_t    commit_data_o,
    output logic                   commit_csr_we_o,
    output backend_pkg::csr_addr_t commit_csr_addr_o,
    output backend_pkg::bus32_t    commit_csr_data_o
);
    import backend_pkg::*;

    bus32_t alu_res;

    // earlier csr write has already landed by now
    assign csr_raddr_o = id_csr_i;

    always_comb begin
        case (id_op_i)
            ALU_ADD:   alu_res = id_src1_i + id_src2_i;
            ALU_SUB:   alu_res = id_src1_i - id_src2_i;
            ALU_AND:   alu_res = id_src1_i & id_src2_i;
            ALU_OR:    alu_res = id_src1_i | id_src2_i;
            ALU_XOR:   alu_res = id_src1_i ^ id_src2_i;
            ALU_SLT:   alu_res = {31'b0, $signed(id_src1_i) < $signed(id_src2_i)};
            ALU_SLTU:  alu_res = {31'b0, id_src1_i < id_src2_i};
            ALU_LUI:   alu_res = id_src2_i;
            // old csr value goes back to rd
            ALU_CSRRD: alu_res = csr_rdata_i;
            ALU_CSRWR: alu_res = csr_rdata_i;
            default:   alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_o  <= 1'b0;
            commit_we_o     <= 1'b0;
            commit_csr_we_o <= 1'b0;
        end else begin
            commit_valid_o  <= id_valid_i;
            commit_we_o     <= id_valid_i && id_we_i;
            commit_csr_we_o <= id_valid_i && (id_op_i == ALU_CSRWR);
        end
    end

    // commit record payload
    always_ff @(posedge clk) begin
        commit_pc_o       <= id_pc_i;
        commit_rd_o       <= id_rd_i;
        commit_data_o     <= alu_res;
        commit_csr_addr_o <= id_csr_i;
        commit_csr_data_o <= id_src1_i;
    end

endmodule

/* backend_top.sv */
`timescale 1ns/1ps

module backend_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   inst_req_i,
    input  backend_pkg::bus32_t    inst_pc_i,
    input  backend_pkg::bus32_t    inst_i,
    output logic                   inst_ack_o,
    output logic                   commit_valid_o,
    output backend_pkg::bus32_t    commit_pc_o,
    output logic                   commit_we_o,
    output backend_pkg::reg_addr_t commit_rd_o,
    output backend_pkg::bus32_t    commit_data_o
);
    import backend_pkg::*;

    // regfile read
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    bus32_t    rdata1;
    bus32_t    rdata2;

    // decode to execute
    logic      id_valid;
    bus32_t    id_pc;
    alu_op_t   id_op;
    reg_addr_t id_rd;
    bus32_t    id_src1;
    bus32_t    id_src2;
    csr_addr_t id_csr;
    logic      id_we;

    // csr side
    csr_addr_t csr_raddr;
    bus32_t    csr_rdata;
    logic      commit_csr_we;
    csr_addr_t commit_csr_addr;
    bus32_t    commit_csr_data;

    decoder u_decoder (
        .clk,
        .arst_n_i,
        .inst_req_i,
        .inst_pc_i,
        .inst_i,
        .inst_ack_o,
        .raddr1_o    (raddr1),
        .raddr2_o    (raddr2),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .fwd_valid_i (commit_valid_o),
        .fwd_we_i    (commit_we_o),
        .fwd_rd_i    (commit_rd_o),
        .fwd_data_i  (commit_data_o),
        .id_valid_o  (id_valid),
        .id_pc_o     (id_pc),
        .id_op_o     (id_op),
        .id_rd_o     (id_rd),
        .id_src1_o   (id_src1),
        .id_src2_o   (id_src2),
        .id_csr_o    (id_csr),
        .id_we_o     (id_we)
    );

    execute u_execute (
        .clk,
        .arst_n_i,
        .id_valid_i        (id_valid),
        .id_pc_i           (id_pc),
        .id_op_i           (id_op),
        .id_rd_i           (id_rd),
        .id_src1_i         (id_src1),
        .id_src2_i         (id_src2),
        .id_csr_i          (id_csr),
        .id_we_i           (id_we),
        .csr_raddr_o       (csr_raddr),
        .csr_rdata_i       (csr_rdata),
        .commit_valid_o,
        .commit_pc_o,
        .commit_we_o,
        .commit_rd_o,
        .commit_data_o,
        .commit_csr_we_o   (commit_csr_we),
        .commit_csr_addr_o (commit_csr_addr),
        .commit_csr_data_o (commit_csr_data)
    );

    regfile u_regfile (
        .clk,
        .arst_n_i,
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (commit_we_o),
        .waddr_i  (commit_rd_o),
        .wdata_i  (commit_data_o)
    );

    csr u_csr (
        .clk,
        .arst_n_i,
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .we_i    (commit_csr_we),
        .waddr_i (commit_csr_addr),
        .wdata_i (commit_csr_data)
    );

endmodule

/* backend_checker.sv */
`timescale 1ns/1ps

module backend_checker (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input logic                   inst_req_i,
    input logic                   inst_ack_i,
    input logic                   commit_valid_i,
    input logic                   commit_we_i,
    input backend_pkg::reg_addr_t commit_rd_i
);

    int unsigned assert_failures = 0;

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(inst_ack_i) |-> $past(inst_req_i))
        else begin
            assert_failures++;
            $error("ack rose without a request");
        end

    req_held_for_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(inst_req_i) |-> inst_ack_i)
        else begin
            assert_failures++;
            $error("request dropped before ack");
        end

    // issue rate is one per two cycles at best
    commit_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_i |=> !commit_valid_i)
        else begin
            assert_failures++;
            $error("commit valid held for two cycles");
        end

    commit_we_not_r0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_we_i |-> (commit_rd_i != '0))
        else begin
            assert_failures++;
            $error("register write to r0 committed");
        end

endmodule

bind backend_top backend_checker u_checker (
    .clk_i          (clk),
    .arst_n_i       (arst_n_i),
    .inst_req_i     (inst_req_i),
    .inst_ack_i     (inst_ack_o),
    .commit_valid_i (commit_valid_o),
    .commit_we_i    (commit_we_o),
    .commit_rd_i    (commit_rd_o)
);

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

/* tb_backend.sv */
`timescale 1ns/1ps

module tb_backend;
    import backend_pkg::*;

    localparam int          CLK_PERIOD_NS = 100;
    localparam int          RST_CYCLES    = 8;
    localparam int unsigned RAND_SEED     = 32'h8a4b_53c1;
    localparam bus32_t      PC_BASE       = 32'h1c00_0000;

    logic      clk;
    logic      arst_n;
    logic      inst_req;
    bus32_t    inst_pc;
    bus32_t    inst;
    logic      inst_ack;
    logic      commit_valid;
    bus32_t    commit_pc;
    logic      commit_we;
    reg_addr_t commit_rd;
    bus32_t    commit_data;

    // one row per instruction
    string     vec_name [$];
    bus32_t    vec_pc   [$];
    bus32_t    vec_inst [$];
    logic      vec_we   [$];
    reg_addr_t vec_rd   [$];
    bus32_t    vec_data [$];
    bit        vec_b2b  [$];

    int commit_count = 0;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    backend_top u_dut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .inst_req_i     (inst_req),
        .inst_pc_i      (inst_pc),
        .inst_i         (inst),
        .inst_ack_o     (inst_ack),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_we_o    (commit_we),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    function automatic bus32_t rrr_inst(input logic [16:0] op, input int rd, input int rj,
                                        input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic bus32_t addi_inst(input int rd, input int rj, input int imm);
        return {OP_ADDI_W, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic bus32_t lu12i_inst(input int rd, input int imm);
        return {OP_LU12I_W, imm[19:0], rd[4:0]};
    endfunction

    // rj = 1 selects csrwr
    function automatic bus32_t csr_inst(input int rd, input csr_addr_t num, input int wr);
        return {OP_CSR, num, 4'b0, wr[0], rd[4:0]};
    endfunction

    task automatic push_entry(input string name, input int b2b, input bus32_t word,
                              input int we, input int rd, input bus32_t data);
        vec_name.push_back(name);
        vec_pc.push_back(PC_BASE + 32'(vec_pc.size() * 4));
        vec_inst.push_back(word);
        vec_we.push_back(we != 0);
        vec_rd.push_back(rd[4:0]);
        vec_data.push_back(data);
        vec_b2b.push_back(b2b != 0);
    endtask

    // name, back-to-back, instruction, we, rd, data
    task automatic build_table();
        push_entry("addi_pos", 0, addi_inst(1, 0, 'h123), 1, 1, 32'h0000_0123);
        push_entry("addi_neg", 0, addi_inst(2, 0, -1), 1, 2, 32'hffff_ffff);
        push_entry("lu12i_upper", 0, lu12i_inst(3, 'h80000), 1, 3, 32'h8000_0000);
        push_entry("add_wrap", 0, rrr_inst(OP_ADD_W, 4, 2, 1), 1, 4, 32'h0000_0122);
        push_entry("sub_neg", 0, rrr_inst(OP_SUB_W, 5, 0, 1), 1, 5, 32'hffff_fedd);
        push_entry("and_mask", 0, rrr_inst(OP_AND, 6, 5, 1), 1, 6, 32'h0000_0001);
        push_entry("or_bits", 0, rrr_inst(OP_OR, 7, 3, 1), 1, 7, 32'h8000_0123);
        push_entry("xor_bits", 0, rrr_inst(OP_XOR, 8, 7, 2), 1, 8, 32'h7fff_fedc);
        push_entry("slt_signed", 0, rrr_inst(OP_SLT, 9, 3, 1), 1, 9, 32'h0000_0001);
        push_entry("sltu_unsigned", 0, rrr_inst(OP_SLTU, 10, 3, 1), 1, 10, 32'h0000_0000);
        // dependent chain issued with no gap
        push_entry("fwd_seed", 0, addi_inst(14, 0, 7), 1, 14, 32'h0000_0007);
        push_entry("fwd_both", 1, rrr_inst(OP_ADD_W, 14, 14, 14), 1, 14, 32'h0000_000e);
        push_entry("fwd_src2", 1, rrr_inst(OP_ADD_W, 15, 1, 14), 1, 15, 32'h0000_0131);
        push_entry("fwd_src1", 1, rrr_inst(OP_SUB_W, 16, 15, 14), 1, 16, 32'h0000_0123);
        push_entry("csrwr_save0", 0, csr_inst(1, CSR_SAVE0, 1), 1, 1, 32'h0000_0000);
        push_entry("csrrd_save0", 1, csr_inst(17, CSR_SAVE0, 0), 1, 17, 32'h0000_0123);
        push_entry("csrwr_save3_fwd", 1, csr_inst(17, CSR_SAVE3, 1), 1, 17, 32'h0000_0000);
        push_entry("csrrd_save3", 1, csr_inst(18, CSR_SAVE3, 0), 1, 18, 32'h0000_0123);
        push_entry("csrwr_save3_swap", 0, csr_inst(7, CSR_SAVE3, 1), 1, 7, 32'h0000_0123);
        push_entry("csrrd_save3_new", 1, csr_inst(19, CSR_SAVE3, 0), 1, 19, 32'h8000_0123);
        push_entry("csrwr_unmapped", 0, csr_inst(8, 14'h0040, 1), 1, 8, 32'h0000_0000);
        push_entry("csrrd_unmapped", 1, csr_inst(20, 14'h0040, 0), 1, 20, 32'h0000_0000);
        push_entry("write_r0", 0, addi_inst(0, 2, 5), 0, 0, 32'h0000_0000);
        push_entry("read_r0", 1, rrr_inst(OP_OR, 22, 0, 0), 1, 22, 32'h0000_0000);
        push_entry("unknown_op", 0, 32'hffff_ffff, 0, 31, 32'h0000_0000);
        push_entry("read_r31", 1, rrr_inst(OP_ADD_W, 23, 31, 0), 1, 23, 32'h0000_0000);
    endtask

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bus32(input string name, input string field, input bus32_t exp,
                               input bus32_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", name, field, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_reg_addr(input string name, input string field,
                                  input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %0d, actual %0d", name, field, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input string field, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", name, field, exp, act);
            end_with_failure();
        end
    endtask

    task automatic score_commit(input int idx);
        check_bus32(vec_name[idx], "pc", vec_pc[idx], commit_pc);
        check_bit(vec_name[idx], "we", vec_we[idx], commit_we);
        check_reg_addr(vec_name[idx], "rd", vec_rd[idx], commit_rd);
        // data only defined when a register is written
        if (vec_we[idx]) begin
            check_bus32(vec_name[idx], "data", vec_data[idx], commit_data);
        end
    endtask

    // hold until ack, then drop req and wait for ack to clear
    task automatic send_request(input bus32_t pc, input bus32_t word);
        inst_req = 1'b1;
        inst_pc  = pc;
        inst     = word;
        @(negedge clk);
        while (!inst_ack) @(negedge clk);
        inst_req = 1'b0;
        @(negedge clk);
        while (inst_ack) @(negedge clk);
    endtask

    // in-order commit scoreboard
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            if (commit_count < vec_pc.size()) begin
                score_commit(commit_count);
                commit_count <= commit_count + 1;
            end else begin
                $display("commit seen after the last instruction, pc %h", commit_pc);
                end_with_failure();
            end
        end
    end

    initial begin : main
        int unsigned gap;
        int unsigned limit_ns;
        inst_req = 1'b0;
        inst_pc  = '0;
        inst     = '0;
        void'($urandom(RAND_SEED));
        build_table();
        limit_ns = (vec_pc.size() * 12 + RST_CYCLES) * CLK_PERIOD_NS;
        fork
            begin
                #(limit_ns);
                $display("timeout: commits missing");
                end_with_failure();
            end
        join_none
        wait (arst_n === 1'b1);
        @(negedge clk);
        for (int i = 0; i < vec_pc.size(); i++) begin
            if (!vec_b2b[i]) begin
                gap = $urandom_range(3, 0);
                repeat (gap) @(negedge clk);
            end
            send_request(vec_pc[i], vec_inst[i]);
        end
        wait (commit_count == vec_pc.size());
        @(negedge clk);
        if (u_dut.u_checker.assert_failures == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

/* build.f */
backend_pkg.sv
regfile.sv
csr.sv
decoder.sv
execute.sv
backend_top.sv
backend_checker.sv
tb_clk_gen.sv
tb_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_backend
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "no result found in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
